// File: files.f
+incdir+testbench
src/sys_bus_pkg.sv
src/mem_map_decoder.sv
src/bus_arbiter.sv
src/main_ram.sv
src/video_ram.sv
src/sys_ports.sv
src/sys_glue_top.sv
testbench/tb_sys_glue.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bus glue testbench with verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_sys_glue --Mdir obj_dir \
  && ./obj_dir/Vtb_sys_glue > sim.log \
  ; cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire sys_bus_pkg::bus_req_t  i_bus,
  input  wire sys_bus_pkg::region_e   i_region,
  input  wire sys_bus_pkg::bus_data_t i_rom_data,
  input  wire sys_bus_pkg::bus_data_t i_ram_rdata,
  input  wire sys_bus_pkg::bus_data_t i_video_rdata,
  input  wire sys_bus_pkg::bus_data_t i_port_rdata,
  output logic                        o_ram_we,
  output logic                        o_video_we,
  output logic                        o_port_we,
  output sys_bus_pkg::bus_data_t      o_rdata
);

  logic w_mem_wr;  // memory write cycle in progress

  assign w_mem_wr = !i_bus.mreq_n && !i_bus.wr_n;

  // exactly one peer can see a strobe per cycle
  assign o_ram_we   = w_mem_wr && (i_region == sys_bus_pkg::REG_RAM);
  assign o_video_we = w_mem_wr && (i_region == sys_bus_pkg::REG_VIDEO);
  assign o_port_we  = w_mem_wr && (i_region == sys_bus_pkg::REG_PORT);

  // read return mux
  always_comb begin
    case (i_region)
      sys_bus_pkg::REG_IO: begin
        o_rdata = 8'hFF;          // nothing answers in io space
      end
      sys_bus_pkg::REG_RAM: begin
        o_rdata = i_ram_rdata;
      end
      sys_bus_pkg::REG_VIDEO: begin
        o_rdata = i_video_rdata;
      end
      sys_bus_pkg::REG_PORT: begin
        o_rdata = i_port_rdata;
      end
      default: begin
        o_rdata = i_rom_data;     // rom windows and unmapped space
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/main_ram.sv
`timescale 1ns/1ps
`default_nettype none

module main_ram #(
  parameter int RAM_ADDR_W = 16
) (
  input  wire                         w_clk_cpu,
  input  wire                         i_we,
  input  wire [RAM_ADDR_W-1:0]        i_addr,
  input  wire sys_bus_pkg::bus_data_t i_wdata,
  output sys_bus_pkg::bus_data_t      o_rdata
);

  sys_bus_pkg::bus_data_t r_mem [2**RAM_ADDR_W];

  always_ff @(posedge w_clk_cpu) begin
    if (i_we) begin
      r_mem[i_addr] <= i_wdata;
    end
    o_rdata <= r_mem[i_addr];  // registered read, old data on a write edge
  end

endmodule

`default_nettype wire

// File: src/mem_map_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mem_map_decoder #(
  parameter int RAM_ADDR_W  = 16,
  parameter int VIDEO_DEPTH = 1536
) (
  input  wire sys_bus_pkg::bus_req_t    i_bus,
  input  wire                           i_page_out,
  output sys_bus_pkg::region_e          o_region,
  output sys_bus_pkg::port_sel_e        o_port_sel,
  output sys_bus_pkg::rom_addr_t        o_rom_addr,
  output logic [RAM_ADDR_W-1:0]         o_ram_addr,
  output logic [$clog2(VIDEO_DEPTH)-1:0] o_video_offset
);

  localparam int VIDEO_AW = $clog2(VIDEO_DEPTH);

  sys_bus_pkg::bus_addr_t w_addr;
  logic [7:0]             w_page;

  assign w_addr = i_bus.addr;
  assign w_page = w_addr[15:8];
  assign o_video_offset = VIDEO_AW'(w_addr - sys_bus_pkg::VIDEO_BASE);  // linear window

  always_comb begin
    o_region   = sys_bus_pkg::REG_NONE;
    o_rom_addr = w_addr[12:0];           // unmatched reads rom at low bits
    o_ram_addr = RAM_ADDR_W'(w_addr);
    if (!i_bus.iorq_n) begin
      o_region = sys_bus_pkg::REG_IO;    // io space, floppy dropped
    end else if ((w_page == sys_bus_pkg::PORT_PAGE) ||
                 ((w_page == sys_bus_pkg::PORT_ALIAS_PAGE) && !i_page_out)) begin
      o_region = sys_bus_pkg::REG_PORT;
    end else if (w_addr >= sys_bus_pkg::VIDEO_BASE && w_addr <= sys_bus_pkg::VIDEO_LAST) begin
      o_region = sys_bus_pkg::REG_VIDEO;
    end else if (w_addr >= sys_bus_pkg::ROM_HI_BASE && w_addr <= sys_bus_pkg::ROM_HI_LAST) begin
      o_region   = sys_bus_pkg::REG_ROM;
      o_rom_addr = 13'(w_addr - sys_bus_pkg::ROM_HI_BASE);
    end else if (w_addr >= sys_bus_pkg::ROM_MID_BASE && w_addr <= sys_bus_pkg::ROM_MID_LAST) begin
      o_region   = sys_bus_pkg::REG_ROM;
      o_rom_addr = 13'(w_addr - sys_bus_pkg::ROM_MID_BASE) + sys_bus_pkg::ROM_MID_OFFS;
    end else if (w_addr >= sys_bus_pkg::RAM_TOP_BASE) begin
      o_region = sys_bus_pkg::REG_RAM;   // top 1k stack ram, never paged
    end else if (!i_page_out) begin
      if (w_addr >= sys_bus_pkg::RAM_LOW_BASE && w_addr <= sys_bus_pkg::RAM_LOW_LAST) begin
        o_region   = sys_bus_pkg::REG_RAM;
        o_ram_addr = RAM_ADDR_W'(w_addr - sys_bus_pkg::RAM_LOW_BASE);
      end else if (w_addr >= sys_bus_pkg::ROM_LOW_BASE &&
                   w_addr <= sys_bus_pkg::ROM_LOW_LAST) begin
        o_region   = sys_bus_pkg::REG_ROM;
        o_rom_addr = 13'(w_addr - sys_bus_pkg::ROM_LOW_BASE) + sys_bus_pkg::ROM_LOW_OFFS;
      end
    end else if (w_addr <= sys_bus_pkg::RAM_PAGED_LAST) begin
      o_region = sys_bus_pkg::REG_RAM;   // flat ram while paged out
    end
  end

  always_comb begin
    case (w_addr[7:0])
      sys_bus_pkg::PORT_OFS_BLANK:  o_port_sel = sys_bus_pkg::PORT_BLANK;
      sys_bus_pkg::PORT_OFS_KEY:    o_port_sel = sys_bus_pkg::PORT_KEY;
      sys_bus_pkg::PORT_OFS_STATUS: o_port_sel = sys_bus_pkg::PORT_STATUS;
      default:                      o_port_sel = sys_bus_pkg::PORT_OTHER;
    endcase
  end

endmodule

`default_nettype wire

// File: src/sys_bus_pkg.sv
`default_nettype none

package sys_bus_pkg;

  typedef logic [15:0] bus_addr_t;   // cpu address
  typedef logic [7:0]  bus_data_t;   // cpu data byte
  typedef logic [12:0] rom_addr_t;   // external rom address

  // one z80 bus cycle, strobes active low
  typedef struct packed {
    logic      mreq_n;
    logic      iorq_n;
    logic      rd_n;
    logic      wr_n;
    logic      m1_n;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef enum logic [2:0] {
    REG_ROM,
    REG_RAM,
    REG_VIDEO,
    REG_PORT,
    REG_IO,
    REG_NONE
  } region_e;

  typedef enum logic [1:0] {
    PORT_BLANK,   // offset 00, blanking status
    PORT_KEY,     // offset fc, key code / port 0
    PORT_STATUS,  // offset fe, blank + key ready
    PORT_OTHER
  } port_sel_e;

  // port 0 control register
  typedef struct packed {
    logic       page_out;  // low 56k becomes ram
    logic       attr_sel;  // video window hits attribute bank
    logic [3:0] unused;    // stored only
    logic       nmi_hold;  // freeze m1 counter
    logic       key_keep;  // clear key ready when written low
  } ctrl_port_t;

  localparam logic [7:0] PORT_PAGE       = 8'hFB;
  localparam logic [7:0] PORT_ALIAS_PAGE = 8'h1B;  // only while page_out clear
  localparam logic [7:0] PORT_OFS_BLANK  = 8'h00;
  localparam logic [7:0] PORT_OFS_KEY    = 8'hFC;
  localparam logic [7:0] PORT_OFS_STATUS = 8'hFE;

  localparam bus_addr_t VIDEO_BASE     = 16'hF000;
  localparam bus_addr_t VIDEO_LAST     = 16'hF5FF;
  localparam bus_addr_t ROM_HI_BASE    = 16'hE000;
  localparam bus_addr_t ROM_HI_LAST    = 16'hEFFF;
  localparam bus_addr_t ROM_MID_BASE   = 16'hF600;
  localparam bus_addr_t ROM_MID_LAST   = 16'hF9FF;
  localparam rom_addr_t ROM_MID_OFFS   = 13'h1000;
  localparam bus_addr_t ROM_LOW_BASE   = 16'h1C00;
  localparam bus_addr_t ROM_LOW_LAST   = 16'h1DFF;
  localparam rom_addr_t ROM_LOW_OFFS   = 13'h1400;
  localparam bus_addr_t RAM_TOP_BASE   = 16'hFC00;
  localparam bus_addr_t RAM_LOW_BASE   = 16'h4000;
  localparam bus_addr_t RAM_LOW_LAST   = 16'h7FFF;
  localparam bus_addr_t RAM_PAGED_LAST = 16'hDFFF;  // paged out ram ceiling

endpackage

`default_nettype wire

// File: src/sys_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module sys_glue_top #(
  parameter int RAM_ADDR_W  = 16,
  parameter int VIDEO_DEPTH = 1536
) (
  input  wire                         w_clk_cpu,
  input  wire                         w_cpu_reset,
  input  wire sys_bus_pkg::bus_req_t  i_bus,
  input  wire sys_bus_pkg::bus_data_t i_rom_data,
  input  wire sys_bus_pkg::bus_data_t i_key_code,
  input  wire                         i_key_press,
  input  wire                         i_hblank,
  input  wire                         i_vblank,
  output sys_bus_pkg::bus_data_t      o_rdata,
  output sys_bus_pkg::rom_addr_t      o_rom_addr,
  output logic                        o_nmi_n
);

  localparam int VIDEO_AW = $clog2(VIDEO_DEPTH);

  sys_bus_pkg::region_e    w_region;
  sys_bus_pkg::port_sel_e  w_port_sel;
  sys_bus_pkg::ctrl_port_t w_ctrl;
  logic [RAM_ADDR_W-1:0]   w_ram_addr;
  logic [VIDEO_AW-1:0]     w_video_offset;
  logic                    w_ram_we;
  logic                    w_video_we;
  logic                    w_port_we;
  sys_bus_pkg::bus_data_t  w_ram_rdata;
  sys_bus_pkg::bus_data_t  w_video_rdata;
  sys_bus_pkg::bus_data_t  w_port_rdata;

  mem_map_decoder #(.RAM_ADDR_W(RAM_ADDR_W), .VIDEO_DEPTH(VIDEO_DEPTH)) u_decoder (
    .i_bus          (i_bus),
    .i_page_out     (w_ctrl.page_out),
    .o_region       (w_region),
    .o_port_sel     (w_port_sel),
    .o_rom_addr     (o_rom_addr),
    .o_ram_addr     (w_ram_addr),
    .o_video_offset (w_video_offset)
  );

  bus_arbiter u_arbiter (
    .i_bus         (i_bus),
    .i_region      (w_region),
    .i_rom_data    (i_rom_data),
    .i_ram_rdata   (w_ram_rdata),
    .i_video_rdata (w_video_rdata),
    .i_port_rdata  (w_port_rdata),
    .o_ram_we      (w_ram_we),
    .o_video_we    (w_video_we),
    .o_port_we     (w_port_we),
    .o_rdata       (o_rdata)
  );

  main_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_main_ram (
    .w_clk_cpu (w_clk_cpu),
    .i_we      (w_ram_we),
    .i_addr    (w_ram_addr),
    .i_wdata   (i_bus.wdata),
    .o_rdata   (w_ram_rdata)
  );

  video_ram #(.VIDEO_DEPTH(VIDEO_DEPTH)) u_video_ram (
    .w_clk_cpu  (w_clk_cpu),
    .i_we       (w_video_we),
    .i_offset   (w_video_offset),
    .i_wdata    (i_bus.wdata),
    .i_attr_sel (w_ctrl.attr_sel),
    .o_rdata    (w_video_rdata)
  );

  sys_ports u_ports (
    .w_clk_cpu   (w_clk_cpu),
    .w_cpu_reset (w_cpu_reset),
    .i_we        (w_port_we),
    .i_port_sel  (w_port_sel),
    .i_bus       (i_bus),
    .i_key_code  (i_key_code),
    .i_key_press (i_key_press),
    .i_hblank    (i_hblank),
    .i_vblank    (i_vblank),
    .o_ctrl      (w_ctrl),
    .o_rdata     (w_port_rdata),
    .o_nmi_n     (o_nmi_n)
  );

endmodule

`default_nettype wire

// File: src/sys_ports.sv
`timescale 1ns/1ps
`default_nettype none

module sys_ports (
  input  wire                         w_clk_cpu,
  input  wire                         w_cpu_reset,
  input  wire                         i_we,
  input  wire sys_bus_pkg::port_sel_e i_port_sel,
  input  wire sys_bus_pkg::bus_req_t  i_bus,
  input  wire sys_bus_pkg::bus_data_t i_key_code,
  input  wire                         i_key_press,
  input  wire                         i_hblank,
  input  wire                         i_vblank,
  output sys_bus_pkg::ctrl_port_t     o_ctrl,
  output sys_bus_pkg::bus_data_t      o_rdata,
  output logic                        o_nmi_n
);

  sys_bus_pkg::ctrl_port_t r_port0;
  logic                    r_key_ready;
  logic [3:0]              r_nmi_cnt;
  logic                    r_m1_prev;   // m1_n one clock ago
  logic                    w_port0_wr;
  logic                    w_m1_fall;

  assign w_port0_wr = i_we && (i_port_sel == sys_bus_pkg::PORT_KEY);
  assign w_m1_fall  = r_m1_prev && !i_bus.m1_n;

  always_ff @(posedge w_clk_cpu or negedge w_cpu_reset) begin
    if (!w_cpu_reset) begin
      r_port0     <= '0;
      r_key_ready <= 1'b0;
      r_nmi_cnt   <= '0;
      r_m1_prev   <= 1'b1;
    end else begin
      r_m1_prev <= i_bus.m1_n;
      if (w_port0_wr) begin
        r_port0 <= i_bus.wdata;
      end

      // new key press beats a software clear
      if (i_key_press) begin
        r_key_ready <= 1'b1;
      end else if (w_port0_wr && !i_bus.wdata[0]) begin
        r_key_ready <= 1'b0;
      end

      if (w_port0_wr && i_bus.wdata[1]) begin
        r_nmi_cnt <= '0;                 // restart nmi timing
      end else if (w_m1_fall && !r_port0.nmi_hold) begin
        r_nmi_cnt <= r_nmi_cnt + 4'd1;   // wraps after 16 fetches
      end
    end
  end

  always_comb begin
    case (i_port_sel)
      sys_bus_pkg::PORT_BLANK: begin
        o_rdata = {6'b111111, ~i_hblank, ~i_vblank};
      end
      sys_bus_pkg::PORT_KEY: begin
        o_rdata = i_key_code;
      end
      sys_bus_pkg::PORT_STATUS: begin
        o_rdata = {i_hblank, i_vblank, 5'b00000, r_key_ready};
      end
      default: begin
        o_rdata = 8'h00;
      end
    endcase
  end

  assign o_ctrl  = r_port0;
  assign o_nmi_n = ~r_nmi_cnt[3];  // low for counts 8..15

endmodule

`default_nettype wire

// File: src/video_ram.sv
`timescale 1ns/1ps
`default_nettype none

module video_ram #(
  parameter int VIDEO_DEPTH = 1536
) (
  input  wire                           w_clk_cpu,
  input  wire                           i_we,
  input  wire [$clog2(VIDEO_DEPTH)-1:0] i_offset,
  input  wire sys_bus_pkg::bus_data_t   i_wdata,
  input  wire                           i_attr_sel,
  output sys_bus_pkg::bus_data_t        o_rdata
);

  // bank 0 holds character codes, bank 1 attributes
  sys_bus_pkg::bus_data_t r_bank [2][VIDEO_DEPTH];

  always_ff @(posedge w_clk_cpu) begin
    if (i_we) begin
      r_bank[i_attr_sel][i_offset] <= i_wdata;  // only the selected bank
    end
    o_rdata <= r_bank[i_attr_sel][i_offset];
  end

endmodule

`default_nettype wire

// File: testbench/tb_sys_model.svh
sys_bus_pkg::bus_data_t m_ram [int];   // keyed by main ram address
sys_bus_pkg::bus_data_t m_vid [int];   // keyed by {bank, offset}
sys_bus_pkg::bus_data_t m_port0;
logic                   m_key_ready;
logic [3:0]             m_nmi_cnt;

function automatic sys_bus_pkg::bus_data_t rom_byte(input logic [12:0] ra);
  return {3'b000, ra[12:8]} ^ ra[7:0];  // high and low address bytes xored
endfunction

// memory map in priority order, ra and ma default to the raw address
function automatic sys_bus_pkg::region_e map_addr(input logic is_io, input logic [15:0] a,
                                                  output logic [12:0] ra, output logic [15:0] ma);
  logic po;
  po = m_port0[7];
  ra = a[12:0];
  ma = a;
  if (is_io) return sys_bus_pkg::REG_IO;
  if (a[15:8] == 8'hFB || (a[15:8] == 8'h1B && !po)) return sys_bus_pkg::REG_PORT;
  if (a >= 16'hF000 && a <= 16'hF5FF) return sys_bus_pkg::REG_VIDEO;
  if (a >= 16'hE000 && a <= 16'hEFFF) begin
    ra = 13'(a - 16'hE000);
    return sys_bus_pkg::REG_ROM;
  end
  if (a >= 16'hF600 && a <= 16'hF9FF) begin
    ra = 13'(a - 16'hF600) + 13'h1000;
    return sys_bus_pkg::REG_ROM;
  end
  if (a >= 16'hFC00) return sys_bus_pkg::REG_RAM;
  if (!po && a >= 16'h4000 && a <= 16'h7FFF) begin
    ma = a - 16'h4000;
    return sys_bus_pkg::REG_RAM;
  end
  if (!po && a >= 16'h1C00 && a <= 16'h1DFF) begin
    ra = 13'(a - 16'h1C00) + 13'h1400;
    return sys_bus_pkg::REG_ROM;
  end
  if (po && a <= 16'hDFFF) return sys_bus_pkg::REG_RAM;
  return sys_bus_pkg::REG_NONE;
endfunction

function automatic sys_bus_pkg::bus_data_t port_byte(input logic [7:0] ofs);
  case (ofs)
    8'h00:   return {6'b111111, ~hblank, ~vblank};
    8'hFC:   return key_code;
    8'hFE:   return {hblank, vblank, 5'b00000, m_key_ready};
    default: return 8'h00;
  endcase
endfunction

// File: testbench/tb_sys_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sys_glue;

  logic                   w_clk_cpu;
  logic                   w_cpu_reset;
  sys_bus_pkg::bus_req_t  bus;
  sys_bus_pkg::bus_data_t rom_data;
  sys_bus_pkg::bus_data_t key_code;
  logic                   key_press;
  logic                   hblank;
  logic                   vblank;
  sys_bus_pkg::bus_data_t rdata;
  sys_bus_pkg::rom_addr_t rom_addr;
  logic                   nmi_n;
  logic [31:0]            rng_state;
  int                     data_errs;
  int                     rom_errs;
  int                     nmi_errs;
  logic [15:0]            addr_q [$];

  `include "tb_sys_model.svh"

  sys_glue_top #(.RAM_ADDR_W(16), .VIDEO_DEPTH(1536)) UUT (
    .w_clk_cpu(w_clk_cpu), .w_cpu_reset(w_cpu_reset), .i_bus(bus), .i_rom_data(rom_data),
    .i_key_code(key_code), .i_key_press(key_press), .i_hblank(hblank), .i_vblank(vblank),
    .o_rdata(rdata), .o_rom_addr(rom_addr), .o_nmi_n(nmi_n)
  );

  assign rom_data = rom_byte(rom_addr);  // combinational rom

  initial begin
    w_clk_cpu = 1'b0;
    forever #4 w_clk_cpu = ~w_clk_cpu;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic sys_bus_pkg::bus_req_t idle_req();
    sys_bus_pkg::bus_req_t r;
    r = '0;
    r.mreq_n = 1'b1;
    r.iorq_n = 1'b1;
    r.rd_n   = 1'b1;
    r.wr_n   = 1'b1;
    r.m1_n   = 1'b1;
    return r;
  endfunction

  task automatic wait_edges(input int n);
    for (int i = 0; i < n; i++) @(posedge w_clk_cpu);
  endtask

  task automatic check_data(input string name, input sys_bus_pkg::bus_data_t exp,
                            input sys_bus_pkg::bus_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_rom_addr(input string name, input sys_bus_pkg::rom_addr_t exp,
                                input sys_bus_pkg::rom_addr_t act);
    if (act !== exp) begin
      rom_errs++;
      $display("[FAIL] %s expected %04h actual %04h", name, exp, act);
    end
  endtask

  task automatic check_nmi(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      nmi_errs++;
      $display("[FAIL] %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  // holds the cycle for two edges and stops mid-period where outputs are settled
  task automatic drive_cycle(input logic is_io, input logic is_wr, input logic [15:0] a,
                             input logic [7:0] d);
    sys_bus_pkg::bus_req_t req;
    req = idle_req();
    req.mreq_n = is_io;
    req.iorq_n = !is_io;
    req.rd_n   = is_wr;
    req.wr_n   = !is_wr;
    req.addr   = a;
    req.wdata  = d;
    @(posedge w_clk_cpu);
    bus <= req;
    wait_edges(2);
    @(negedge w_clk_cpu);
  endtask

  task automatic end_cycle();
    @(posedge w_clk_cpu);
    bus <= idle_req();
  endtask

  task automatic write_cycle(input logic is_io, input logic [15:0] a, input logic [7:0] d);
    logic [12:0] ra;
    logic [15:0] ma;
    sys_bus_pkg::region_e reg_e;
    drive_cycle(is_io, 1'b1, a, d);
    reg_e = map_addr(is_io, a, ra, ma);
    if (reg_e == sys_bus_pkg::REG_RAM) m_ram[ma] = d;
    if (reg_e == sys_bus_pkg::REG_VIDEO) m_vid[{m_port0[6], a - 16'hF000}] = d;
    if (reg_e == sys_bus_pkg::REG_PORT && a[7:0] == 8'hFC) begin
      m_port0 = d;
      if (!d[0]) m_key_ready = 1'b0;
      if (d[1]) m_nmi_cnt = 4'd0;
    end
    end_cycle();
  endtask

  task automatic read_check(input string name, input logic is_io, input logic [15:0] a);
    logic [12:0] ra;
    logic [15:0] ma;
    sys_bus_pkg::region_e reg_e;
    sys_bus_pkg::bus_data_t exp;
    drive_cycle(is_io, 1'b0, a, 8'h00);
    reg_e = map_addr(is_io, a, ra, ma);
    case (reg_e)
      sys_bus_pkg::REG_IO:    exp = 8'hFF;
      sys_bus_pkg::REG_RAM:   exp = m_ram.exists(ma) ? m_ram[ma] : 8'hxx;
      sys_bus_pkg::REG_VIDEO: exp = m_vid[{m_port0[6], a - 16'hF000}];
      sys_bus_pkg::REG_PORT:  exp = port_byte(a[7:0]);
      default:                exp = rom_byte(ra);
    endcase
    check_data(name, exp, rdata);
    if (reg_e == sys_bus_pkg::REG_ROM || reg_e == sys_bus_pkg::REG_NONE) begin
      check_rom_addr(name, ra, rom_addr);  // rom address only defined for rom reads
    end
    end_cycle();
  endtask

  task automatic m1_pulse();
    @(posedge w_clk_cpu);
    bus.m1_n <= 1'b0;
    @(posedge w_clk_cpu);
    bus.m1_n <= 1'b1;
    if (!m_port0[1]) m_nmi_cnt = m_nmi_cnt + 4'd1;
  endtask

  task automatic nmi_after(input string name, input int pulses);
    for (int i = 0; i < pulses; i++) m1_pulse();
    @(negedge w_clk_cpu);  // counter moved on the last pulse edge
    check_nmi(name, ~m_nmi_cnt[3], nmi_n);
  endtask

  task automatic pulse_key();
    @(posedge w_clk_cpu);
    key_press <= 1'b1;
    @(posedge w_clk_cpu);
    key_press <= 1'b0;
    m_key_ready = 1'b1;
  endtask

  // stops a stuck run
  initial begin
    for (int i = 0; i < 200000; i++) @(posedge w_clk_cpu);
    $display("timeout: the testbench did not finish within its cycle limit");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    bus = idle_req();
    key_code = 8'h00;
    key_press = 1'b0;
    hblank = 1'b0;
    vblank = 1'b0;
    w_cpu_reset = 1'b0;
    rng_state = 32'h8dd26739;
    m_port0 = 8'h00;
    m_key_ready = 1'b0;
    m_nmi_cnt = 4'd0;
    data_errs = 0;
    rom_errs = 0;
    nmi_errs = 0;
    wait_edges(16);
    w_cpu_reset <= 1'b1;
    wait_edges(2);
    check_nmi("nmi after reset", 1'b1, nmi_n);

    write_cycle(1'b0, 16'hFBFC, 8'h01);  // page_out clear, keep key
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      addr_q.push_back(r[0] ? 16'h4000 + 16'(r[29:16]) : 16'hFC00 + 16'(r[25:16]));
      write_cycle(1'b0, addr_q[i], r[7:0]);
    end
    foreach (addr_q[i]) read_check("ram low map", 1'b0, addr_q[i]);
    write_cycle(1'b0, 16'h4123, 8'h5A);
    write_cycle(1'b0, 16'hFBFC, 8'h81);  // page_out set
    read_check("ram alias 4123 at 0123", 1'b0, 16'h0123);
    addr_q.delete();
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      addr_q.push_back(16'(r[31:16] % 32'hE000));
      write_cycle(1'b0, addr_q[i], r[7:0]);
    end
    write_cycle(1'b0, 16'h1B40, 8'hC3);
    addr_q.push_back(16'h1B40);
    foreach (addr_q[i]) read_check("ram paged map", 1'b0, addr_q[i]);

    write_cycle(1'b0, 16'hFBFC, 8'h41);  // attribute bank
    addr_q.delete();
    for (int i = 0; i < 10; i++) begin
      r = next_rand();
      addr_q.push_back(16'hF000 + 16'(r[31:16] % 32'd1536));
      write_cycle(1'b0, addr_q[i], r[7:0]);
    end
    write_cycle(1'b0, 16'hFBFC, 8'h01);  // character bank
    foreach (addr_q[i]) write_cycle(1'b0, addr_q[i], ~addr_q[i][7:0]);
    foreach (addr_q[i]) read_check("video char bank", 1'b0, addr_q[i]);
    write_cycle(1'b0, 16'hFBFC, 8'h41);
    foreach (addr_q[i]) read_check("video attr bank", 1'b0, addr_q[i]);
    write_cycle(1'b0, 16'hFBFC, 8'h01);

    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      read_check("rom e000 window", 1'b0, 16'hE000 + 16'(r[27:16]));
      read_check("rom f600 window", 1'b0, 16'hF600 + 16'(r[25:16]));
      read_check("rom 1c00 window", 1'b0, 16'h1C00 + 16'(r[24:16]));
      read_check("unmapped rom", 1'b0, 16'(r[31:16] % 32'h1B00));
    end

    r = next_rand();
    @(posedge w_clk_cpu);
    key_code <= r[7:0];
    hblank <= r[8];
    vblank <= r[9];
    pulse_key();
    read_check("status key ready set", 1'b0, 16'hFBFE);
    read_check("key code", 1'b0, 16'hFBFC);
    read_check("blank port", 1'b0, 16'hFB00);
    read_check("other port", 1'b0, 16'hFB77);
    read_check("alias status", 1'b0, 16'h1BFE);
    write_cycle(1'b0, 16'hFBFC, 8'h00);
    read_check("status key ready clear", 1'b0, 16'hFBFE);

    write_cycle(1'b0, 16'hFBFC, 8'h01);
    nmi_after("nmi after 7 edges", 7);
    nmi_after("nmi after 8 edges", 1);
    nmi_after("nmi after 16 edges", 8);
    nmi_after("nmi low again", 8);
    write_cycle(1'b0, 16'hFBFC, 8'h03);  // clear and hold
    nmi_after("nmi cleared by port write", 0);
    nmi_after("nmi held", 10);
    write_cycle(1'b0, 16'hFBFC, 8'h01);
    nmi_after("nmi released", 8);

    write_cycle(1'b0, 16'hFC10, 8'h96);
    write_cycle(1'b0, 16'hF010, 8'hA5);  // known char byte under the io write
    read_check("io read", 1'b1, 16'hFC10);
    write_cycle(1'b1, 16'hFC10, 8'h69);
    write_cycle(1'b1, 16'hFBFC, 8'h83);
    write_cycle(1'b1, 16'hF010, 8'h11);
    pulse_key();
    write_cycle(1'b1, 16'hFBFC, 8'h00);
    read_check("ram after io write", 1'b0, 16'hFC10);
    read_check("key ready after io write", 1'b0, 16'hFBFE);
    read_check("video after io write", 1'b0, 16'hF010);
    check_nmi("nmi after io write", ~m_nmi_cnt[3], nmi_n);

    $display("errors: data %0d, rom address %0d, nmi %0d", data_errs, rom_errs, nmi_errs);
    if (data_errs + rom_errs + nmi_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
